// File: Bender.yml
package:
  name: u2_ctrl_core

sources:
  # RTL, packages first
  - logic/u2_types_pkg.sv
  - logic/u2_regmap_pkg.sv
  - logic/settings_in.sv
  - logic/misc_regs.sv
  - logic/vita_timer.sv
  - logic/readback_mux.sv
  - logic/u2_ctrl_core.sv

  # Simulation only
  - target: simulation
    files:
      - sim/u2_ctrl_core_properties.sv
      - sim/u2_ctrl_core_tb.sv

// File: logic/misc_regs.sv
`default_nettype none

module misc_regs (
   input  wire                            dsp_clk,
   input  wire                            reset_i,
   input  wire u2_types_pkg::reg_write_t  wr_i,
   input  wire u2_types_pkg::led_hw_t     led_hw_i,
   output u2_types_pkg::serdes_ctrl_t     serdes_ctrl_o,
   output u2_types_pkg::adc_ctrl_t        adc_ctrl_o,
   output logic                           phy_reset_n_o,
   output u2_types_pkg::led_t             leds_o,
   output logic [15:0]                    ctrl_rb_o
);

   import u2_types_pkg::*;
   import u2_regmap_pkg::*;

   led_t led_sw_q;
   led_t led_src_q;
   led_t led_hw_vec;
   logic phy_rst_q;

   ////////////////////////////////////////////////////////////////////////////
   // Control registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         serdes_ctrl_o <= '0;
         adc_ctrl_o    <= '0;
         led_sw_q      <= '0;
         phy_rst_q     <= 1'b0;
         led_src_q     <= LED_SRC_RESET;
      end else begin
         if (wr_i.serdes) begin
            serdes_ctrl_o <= serdes_ctrl_t'(wr_i.data[3:0]);
         end
         if (wr_i.adc) begin
            adc_ctrl_o <= adc_ctrl_t'(wr_i.data[3:0]);
         end
         if (wr_i.led_sw) begin
            led_sw_q <= wr_i.data[7:0];
         end
         if (wr_i.phy) begin
            phy_rst_q <= wr_i.data[0];
         end
         if (wr_i.led_src) begin
            led_src_q <= wr_i.data[7:0];
         end
      end
   end

   // PHY reset pin is active low
   assign phy_reset_n_o = ~phy_rst_q;

   ////////////////////////////////////////////////////////////////////////////
   // LED source select
   ////////////////////////////////////////////////////////////////////////////

   // Hardware status on bits 4..1
   assign led_hw_vec = {3'b000, led_hw_i, 1'b0};

   // A set led_src bit hands the LED to hardware
   assign leds_o = (led_src_q & led_hw_vec) | (~led_src_q & led_sw_q);

   assign ctrl_rb_o = {led_src_q, serdes_ctrl_o, adc_ctrl_o};

endmodule

`default_nettype wire

// File: logic/readback_mux.sv
`default_nettype none

module readback_mux #(
   parameter u2_types_pkg::set_data_t COMPAT_NUM = u2_regmap_pkg::COMPAT_DEFAULT
) (
   input  wire                           dsp_clk,
   input  wire                           reset_i,
   input  wire u2_types_pkg::rb_addr_t   rb_addr_i,
   input  wire u2_types_pkg::vita_time_t vita_time_i,
   input  wire u2_types_pkg::vita_time_t vita_time_pps_i,
   input  wire [15:0]                    ctrl_rb_i,
   input  wire                           clk_status_i,
   input  wire                           link_up_i,
   output u2_types_pkg::set_data_t       rb_data_o
);

   import u2_types_pkg::*;
   import u2_regmap_pkg::*;

   set_data_t rb_sel;

   // Word select
   always_comb begin
      case (rb_addr_i)
         RB_TIME_HI: rb_sel = vita_time_i[63:32];
         RB_TIME_LO: rb_sel = vita_time_i[31:0];
         RB_PPS_HI:  rb_sel = vita_time_pps_i[63:32];
         RB_PPS_LO:  rb_sel = vita_time_pps_i[31:0];
         RB_COMPAT:  rb_sel = COMPAT_NUM;
         // clk_status at bit 11, link_up at bit 10
         RB_STATUS:  rb_sel = {20'd0, clk_status_i, link_up_i, 10'd0};
         RB_CTRL:    rb_sel = {16'd0, ctrl_rb_i};
         default:    rb_sel = '0;
      endcase
   end

   // One cycle of read latency
   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         rb_data_o <= '0;
      end else begin
         rb_data_o <= rb_sel;
      end
   end

endmodule

`default_nettype wire

// File: logic/settings_in.sv
`default_nettype none

module settings_in #(
   parameter u2_types_pkg::set_addr_t MISC_BASE = u2_regmap_pkg::SR_MISC_DEFAULT,
   parameter u2_types_pkg::set_addr_t TIME_BASE = u2_regmap_pkg::SR_TIME64_DEFAULT
) (
   input  wire                              dsp_clk,
   input  wire                              reset_i,
   input  wire u2_types_pkg::settings_bus_t set_i,
   output u2_types_pkg::reg_write_t         wr_o
);

   import u2_types_pkg::*;
   import u2_regmap_pkg::*;

   // Absolute register addresses
   localparam set_addr_t ADDR_SERDES  = MISC_BASE + OFS_SERDES;
   localparam set_addr_t ADDR_ADC     = MISC_BASE + OFS_ADC;
   localparam set_addr_t ADDR_LED_SW  = MISC_BASE + OFS_LED_SW;
   localparam set_addr_t ADDR_PHY     = MISC_BASE + OFS_PHY;
   localparam set_addr_t ADDR_LED_SRC = MISC_BASE + OFS_LED_SRC;
   localparam set_addr_t ADDR_TIME_HI = TIME_BASE + OFS_TIME_HI;
   localparam set_addr_t ADDR_TIME_LO = TIME_BASE + OFS_TIME_LO;

   reg_write_t wr_d;

   // Address decode, selects stay low without a strobe
   always_comb begin
      wr_d      = '0;
      wr_d.data = set_i.data;
      if (set_i.stb) begin
         wr_d.serdes  = (set_i.addr == ADDR_SERDES);
         wr_d.adc     = (set_i.addr == ADDR_ADC);
         wr_d.led_sw  = (set_i.addr == ADDR_LED_SW);
         wr_d.phy     = (set_i.addr == ADDR_PHY);
         wr_d.led_src = (set_i.addr == ADDR_LED_SRC);
         wr_d.time_hi = (set_i.addr == ADDR_TIME_HI);
         wr_d.time_lo = (set_i.addr == ADDR_TIME_LO);
      end
   end

   // Selects valid one cycle after the strobe
   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         wr_o <= '0;
      end else begin
         wr_o <= wr_d;
      end
   end

endmodule

`default_nettype wire

// File: logic/u2_ctrl_core.sv
`default_nettype none

module u2_ctrl_core #(
   parameter u2_types_pkg::set_addr_t MISC_BASE  = u2_regmap_pkg::SR_MISC_DEFAULT,
   parameter u2_types_pkg::set_addr_t TIME_BASE  = u2_regmap_pkg::SR_TIME64_DEFAULT,
   parameter u2_types_pkg::set_data_t COMPAT_NUM = u2_regmap_pkg::COMPAT_DEFAULT
) (
   input  wire                              dsp_clk,
   input  wire                              reset_i,
   input  wire u2_types_pkg::settings_bus_t set_i,
   input  wire                              pps_i,
   input  wire                              run_rx_i,
   input  wire                              run_tx_i,
   input  wire                              clk_status_i,
   input  wire                              link_up_i,
   input  wire                              good_sync_i,
   input  wire u2_types_pkg::rb_addr_t      rb_addr_i,
   output u2_types_pkg::serdes_ctrl_t       serdes_ctrl_o,
   output u2_types_pkg::adc_ctrl_t          adc_ctrl_o,
   output logic                             phy_reset_n_o,
   output u2_types_pkg::led_t               leds_o,
   output u2_types_pkg::set_data_t          rb_data_o
);

   import u2_types_pkg::*;

   reg_write_t  wr;
   led_hw_t     led_hw;
   vita_time_t  vita_time;
   vita_time_t  vita_time_pps;
   logic [15:0] ctrl_rb;

   // Sync LED is lit only with the link up and in sync
   assign led_hw = '{
      run_tx:     run_tx_i,
      run_rx:     run_rx_i,
      clk_status: clk_status_i,
      sync_ok:    link_up_i & good_sync_i
   };

   ////////////////////////////////////////////////////////////////////////////
   // Settings input, register blocks, readback
   ////////////////////////////////////////////////////////////////////////////

   settings_in #(
      .MISC_BASE (MISC_BASE),
      .TIME_BASE (TIME_BASE)
   ) i_settings_in (
      .dsp_clk (dsp_clk),
      .reset_i (reset_i),
      .set_i   (set_i),
      .wr_o    (wr)
   );

   misc_regs i_misc_regs (
      .dsp_clk       (dsp_clk),
      .reset_i       (reset_i),
      .wr_i          (wr),
      .led_hw_i      (led_hw),
      .serdes_ctrl_o (serdes_ctrl_o),
      .adc_ctrl_o    (adc_ctrl_o),
      .phy_reset_n_o (phy_reset_n_o),
      .leds_o        (leds_o),
      .ctrl_rb_o     (ctrl_rb)
   );

   vita_timer i_vita_timer (
      .dsp_clk         (dsp_clk),
      .reset_i         (reset_i),
      .wr_i            (wr),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps)
   );

   readback_mux #(
      .COMPAT_NUM (COMPAT_NUM)
   ) i_readback_mux (
      .dsp_clk         (dsp_clk),
      .reset_i         (reset_i),
      .rb_addr_i       (rb_addr_i),
      .vita_time_i     (vita_time),
      .vita_time_pps_i (vita_time_pps),
      .ctrl_rb_i       (ctrl_rb),
      .clk_status_i    (clk_status_i),
      .link_up_i       (link_up_i),
      .rb_data_o       (rb_data_o)
   );

endmodule

`default_nettype wire

// File: logic/u2_regmap_pkg.sv
`default_nettype none

package u2_regmap_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Settings bus bases and offsets
   ////////////////////////////////////////////////////////////////////////////

   localparam u2_types_pkg::set_addr_t SR_MISC_DEFAULT   = 8'd0;
   localparam u2_types_pkg::set_addr_t SR_TIME64_DEFAULT = 8'd10;

   // Offsets from the misc base
   localparam u2_types_pkg::set_addr_t OFS_SERDES  = 8'd1;
   localparam u2_types_pkg::set_addr_t OFS_ADC     = 8'd2;
   localparam u2_types_pkg::set_addr_t OFS_LED_SW  = 8'd3;
   localparam u2_types_pkg::set_addr_t OFS_PHY     = 8'd4;
   localparam u2_types_pkg::set_addr_t OFS_LED_SRC = 8'd6;

   // Offsets from the time base
   localparam u2_types_pkg::set_addr_t OFS_TIME_HI = 8'd0;
   localparam u2_types_pkg::set_addr_t OFS_TIME_LO = 8'd1;

   // Bits 4..1 driven by hardware status after reset
   localparam u2_types_pkg::led_t LED_SRC_RESET = 8'b0001_1110;

   // Major in the upper half, minor in the lower half
   localparam u2_types_pkg::set_data_t COMPAT_DEFAULT = {16'd9, 16'd0};

   ////////////////////////////////////////////////////////////////////////////
   // Readback word indices, all others read zero
   ////////////////////////////////////////////////////////////////////////////

   localparam u2_types_pkg::rb_addr_t RB_TIME_HI = 4'd0;
   localparam u2_types_pkg::rb_addr_t RB_TIME_LO = 4'd1;
   localparam u2_types_pkg::rb_addr_t RB_PPS_HI  = 4'd2;
   localparam u2_types_pkg::rb_addr_t RB_PPS_LO  = 4'd3;
   localparam u2_types_pkg::rb_addr_t RB_COMPAT  = 4'd4;
   localparam u2_types_pkg::rb_addr_t RB_STATUS  = 4'd5;
   localparam u2_types_pkg::rb_addr_t RB_CTRL    = 4'd6;

endpackage

`default_nettype wire

// File: logic/u2_types_pkg.sv
`default_nettype none

package u2_types_pkg;

   // Widths with a meaning of their own
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [63:0] vita_time_t;
   typedef logic [7:0]  led_t;
   typedef logic [3:0]  rb_addr_t;

   // Settings bus write, one word per strobe
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } settings_bus_t;

   // Decoded write, one-hot selects plus the registered data word
   typedef struct packed {
      logic      serdes;
      logic      adc;
      logic      led_sw;
      logic      phy;
      logic      led_src;
      logic      time_hi;
      logic      time_lo;
      set_data_t data;
   } reg_write_t;

   // SERDES control pins, MSB first as in data[3:0]
   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   // Hardware LED sources
   typedef struct packed {
      logic run_tx;
      logic run_rx;
      logic clk_status;
      logic sync_ok;
   } led_hw_t;

endpackage

`default_nettype wire

// File: logic/vita_timer.sv
`default_nettype none

module vita_timer (
   input  wire                           dsp_clk,
   input  wire                           reset_i,
   input  wire u2_types_pkg::reg_write_t wr_i,
   input  wire                           pps_i,
   output u2_types_pkg::vita_time_t      vita_time_o,
   output u2_types_pkg::vita_time_t      vita_time_pps_o
);

   import u2_types_pkg::*;

   vita_time_t time_q;
   vita_time_t pps_time_q;
   set_data_t  hold_q;
   logic [2:0] pps_sync_q;
   logic       pps_rise;

   ////////////////////////////////////////////////////////////////////////////
   // Time counter
   ////////////////////////////////////////////////////////////////////////////

   // Upper word waits here until the lower word arrives
   always_ff @(posedge dsp_clk) begin
      if (wr_i.time_hi) begin
         hold_q <= wr_i.data;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         time_q <= '0;
      end else if (wr_i.time_lo) begin
         time_q <= {hold_q, wr_i.data};
      end else begin
         time_q <= time_q + 64'd1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // PPS capture
   ////////////////////////////////////////////////////////////////////////////

   // Two sync stages, third flop for the edge
   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         pps_sync_q <= '0;
      end else begin
         pps_sync_q <= {pps_sync_q[1:0], pps_i};
      end
   end

   assign pps_rise = pps_sync_q[1] & ~pps_sync_q[2];

   // Captured value is two ticks past the first high sample
   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         pps_time_q <= '0;
      end else if (pps_rise) begin
         pps_time_q <= time_q;
      end
   end

   assign vita_time_o     = time_q;
   assign vita_time_pps_o = pps_time_q;

endmodule

`default_nettype wire

// File: sim/u2_ctrl_core_properties.sv
`default_nettype none

module u2_ctrl_core_properties (
   input wire                             dsp_clk,
   input wire                             reset_i,
   input wire                             run_rx_i,
   input wire                             run_tx_i,
   input wire                             clk_status_i,
   input wire                             link_up_i,
   input wire                             good_sync_i,
   input wire u2_types_pkg::serdes_ctrl_t serdes_ctrl_i,
   input wire u2_types_pkg::adc_ctrl_t    adc_ctrl_i,
   input wire                             phy_reset_n_i,
   input wire u2_types_pkg::led_t         leds_i,
   input wire u2_types_pkg::set_data_t    rb_data_i,
   input wire u2_types_pkg::serdes_ctrl_t exp_serdes_i,
   input wire u2_types_pkg::adc_ctrl_t    exp_adc_i,
   input wire                             exp_phy_reset_n_i,
   input wire u2_types_pkg::led_t         exp_led_sw_i,
   input wire u2_types_pkg::led_t         exp_led_src_i,
   input wire                             rb_check_i,
   input wire u2_types_pkg::set_data_t    rb_expect_i
);

   import u2_types_pkg::*;

   led_t        hw_leds;
   led_t        led_exp;
   int unsigned fail_cnt = 0;

   // Hardware status on bits 4..1, sync LED needs link and sync
   assign hw_leds = {3'b000, run_tx_i, run_rx_i, clk_status_i, link_up_i & good_sync_i, 1'b0};

   // Per-bit source choice
   always_comb begin
      for (int i = 0; i < 8; i++) begin
         led_exp[i] = exp_led_src_i[i] ? hw_leds[i] : exp_led_sw_i[i];
      end
   end

   reset_values: assert property (@(posedge dsp_clk)
      reset_i |=> (serdes_ctrl_i == '0 && adc_ctrl_i == '0 && phy_reset_n_i && rb_data_i == '0))
      else begin
         fail_cnt++;
         $error("ERROR %0t: outputs not at their reset values", $time);
      end

   regs_match: assert property (@(posedge dsp_clk) disable iff (reset_i)
      serdes_ctrl_i == exp_serdes_i && adc_ctrl_i == exp_adc_i
      && phy_reset_n_i == exp_phy_reset_n_i)
      else begin
         fail_cnt++;
         $error("ERROR %0t: control outputs %h %h %b, expected %h %h %b", $time,
                $sampled(serdes_ctrl_i), $sampled(adc_ctrl_i), $sampled(phy_reset_n_i),
                $sampled(exp_serdes_i), $sampled(exp_adc_i), $sampled(exp_phy_reset_n_i));
      end

   leds_rule: assert property (@(posedge dsp_clk) disable iff (reset_i) leds_i == led_exp)
      else begin
         fail_cnt++;
         $error("ERROR %0t: leds_o %b, expected %b", $time, $sampled(leds_i), $sampled(led_exp));
      end

   readback_word: assert property (@(posedge dsp_clk) disable iff (reset_i)
      rb_check_i |-> rb_data_i == rb_expect_i)
      else begin
         fail_cnt++;
         $error("ERROR %0t: rb_data_o %h, expected %h", $time,
                $sampled(rb_data_i), $sampled(rb_expect_i));
      end

endmodule

`default_nettype wire

// File: sim/u2_ctrl_core_tb.sv
`default_nettype none

module u2_ctrl_core_tb;

   import u2_types_pkg::*;
   import u2_regmap_pkg::*;

   localparam set_addr_t ADDR_SERDES  = SR_MISC_DEFAULT + OFS_SERDES;
   localparam set_addr_t ADDR_ADC     = SR_MISC_DEFAULT + OFS_ADC;
   localparam set_addr_t ADDR_LED_SW  = SR_MISC_DEFAULT + OFS_LED_SW;
   localparam set_addr_t ADDR_PHY     = SR_MISC_DEFAULT + OFS_PHY;
   localparam set_addr_t ADDR_LED_SRC = SR_MISC_DEFAULT + OFS_LED_SRC;
   localparam set_addr_t ADDR_TIME_HI = SR_TIME64_DEFAULT + OFS_TIME_HI;
   localparam set_addr_t ADDR_TIME_LO = SR_TIME64_DEFAULT + OFS_TIME_LO;

   // Loop counts and worst-case cycles per test
   localparam int N_WRITES       = 24;
   localparam int N_LED          = 16;
   localparam int N_TIME         = 5;
   localparam int N_PPS          = 3;
   localparam int RUN_CYCLES     = 9 + 2 * N_WRITES + 6 * N_LED + 16 * N_TIME + 20 * N_PPS + 40;
   localparam int TIMEOUT_CYCLES = RUN_CYCLES + 200;

   logic          dsp_clk;
   logic          reset;
   settings_bus_t set_bus;
   logic          pps, run_rx, run_tx, clk_status, link_up, good_sync;
   rb_addr_t      rb_addr;
   serdes_ctrl_t  serdes_ctrl;
   adc_ctrl_t     adc_ctrl;
   logic          phy_reset_n;
   led_t          leds;
   set_data_t     rb_data;

   // Register model and readback expectation
   serdes_ctrl_t  model_serdes;
   adc_ctrl_t     model_adc;
   logic          model_phy_n;
   led_t          model_led_sw, model_led_src;
   logic          rb_check;
   set_data_t     rb_expect;

   vita_time_t    time_base;
   int            load_edge;
   int            cycle = 0;
   logic [31:0]   lfsr_state;
   int            tests_run, tests_failed, fails_before;

   u2_ctrl_core i_u2_ctrl_core (
      .dsp_clk       (dsp_clk),
      .reset_i       (reset),
      .set_i         (set_bus),
      .pps_i         (pps),
      .run_rx_i      (run_rx),
      .run_tx_i      (run_tx),
      .clk_status_i  (clk_status),
      .link_up_i     (link_up),
      .good_sync_i   (good_sync),
      .rb_addr_i     (rb_addr),
      .serdes_ctrl_o (serdes_ctrl),
      .adc_ctrl_o    (adc_ctrl),
      .phy_reset_n_o (phy_reset_n),
      .leds_o        (leds),
      .rb_data_o     (rb_data)
   );

   bind u2_ctrl_core u2_ctrl_core_properties i_props (
      .dsp_clk           (dsp_clk),
      .reset_i           (reset_i),
      .run_rx_i          (run_rx_i),
      .run_tx_i          (run_tx_i),
      .clk_status_i      (clk_status_i),
      .link_up_i         (link_up_i),
      .good_sync_i       (good_sync_i),
      .serdes_ctrl_i     (serdes_ctrl_o),
      .adc_ctrl_i        (adc_ctrl_o),
      .phy_reset_n_i     (phy_reset_n_o),
      .leds_i            (leds_o),
      .rb_data_i         (rb_data_o),
      .exp_serdes_i      (u2_ctrl_core_tb.model_serdes),
      .exp_adc_i         (u2_ctrl_core_tb.model_adc),
      .exp_phy_reset_n_i (u2_ctrl_core_tb.model_phy_n),
      .exp_led_sw_i      (u2_ctrl_core_tb.model_led_sw),
      .exp_led_src_i     (u2_ctrl_core_tb.model_led_src),
      .rb_check_i        (u2_ctrl_core_tb.rb_check),
      .rb_expect_i       (u2_ctrl_core_tb.rb_expect)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #4 dsp_clk = ~dsp_clk;
   end

   always @(posedge dsp_clk) cycle <= cycle + 1;

   initial begin
      wait (cycle >= TIMEOUT_CYCLES);
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////////////////////

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [63:0] random_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         r = {r[62:0], lfsr_state[0]};
      end
      return r;
   endfunction

   task automatic drive_status();
      {run_rx, run_tx, clk_status, link_up, good_sync} = 5'(random_bits(5));
   endtask

   task automatic write_setting(input set_addr_t wr_addr, input set_data_t wr_data);
      set_bus = '{stb: 1'b1, addr: wr_addr, data: wr_data};
      @(negedge dsp_clk);
      set_bus = '0;
      // Register output changes one edge after the decode
      @(negedge dsp_clk);
      case (wr_addr)
         ADDR_SERDES:  model_serdes  = serdes_ctrl_t'(wr_data[3:0]);
         ADDR_ADC:     model_adc     = adc_ctrl_t'(wr_data[3:0]);
         ADDR_LED_SW:  model_led_sw  = wr_data[7:0];
         ADDR_PHY:     model_phy_n   = ~wr_data[0];
         ADDR_LED_SRC: model_led_src = wr_data[7:0];
         default: ;
      endcase
   endtask

   task automatic load_time(input vita_time_t t);
      set_bus = '{stb: 1'b1, addr: ADDR_TIME_HI, data: t[63:32]};
      @(negedge dsp_clk);
      set_bus = '{stb: 1'b1, addr: ADDR_TIME_LO, data: t[31:0]};
      @(negedge dsp_clk);
      set_bus = '0;
      time_base = t;
      load_edge = cycle + 1;
   endtask

   // Word for the address lands one edge later and is checked at the next edge
   task automatic read_expect(input rb_addr_t addr, input set_data_t value);
      rb_addr = addr;
      @(negedge dsp_clk);
      rb_check  = 1'b1;
      rb_expect = value;
      @(negedge dsp_clk);
      rb_check = 1'b0;
   endtask

   task automatic finish_test(input string name);
      int fails;
      fails = i_u2_ctrl_core.i_props.fail_cnt - fails_before;
      tests_run++;
      if (fails != 0) begin
         tests_failed++;
         $display("test %s: failed with %0d assertion failures", name, fails);
      end else begin
         $display("test %s: passed", name);
      end
      fails_before = i_u2_ctrl_core.i_props.fail_cnt;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int         k;
      vita_time_t t;
      set_data_t  d;
      logic [1:0] kind;

      reset         = 1'b1;
      set_bus       = '0;
      pps           = 1'b0;
      run_rx        = 1'b0;
      run_tx        = 1'b0;
      clk_status    = 1'b0;
      link_up       = 1'b0;
      good_sync     = 1'b0;
      rb_addr       = '0;
      model_serdes  = '0;
      model_adc     = '0;
      model_phy_n   = 1'b1;
      model_led_sw  = '0;
      model_led_src = LED_SRC_RESET;
      rb_check      = 1'b0;
      rb_expect     = '0;
      time_base     = '0;
      load_edge     = 0;
      lfsr_state    = 32'h2f23;
      tests_run     = 0;
      tests_failed  = 0;
      fails_before  = 0;

      repeat (5) @(negedge dsp_clk);
      reset = 1'b0;
      // Reset LED sources seen with random hardware status
      for (int i = 0; i < 4; i++) begin
         drive_status();
         @(negedge dsp_clk);
      end
      finish_test("reset_values");

      // Unused addresses all have the top bit set
      for (int i = 0; i < N_WRITES; i++) begin
         drive_status();
         d    = 32'(random_bits(32));
         kind = 2'(random_bits(2));
         case (kind)
            2'd0:    write_setting(ADDR_SERDES, d);
            2'd1:    write_setting(ADDR_ADC, d);
            2'd2:    write_setting(ADDR_PHY, d);
            default: write_setting({1'b1, d[30:24]}, d);
         endcase
      end
      finish_test("register_writes");

      for (int i = 0; i < N_LED; i++) begin
         write_setting(ADDR_LED_SW, 32'(random_bits(8)));
         drive_status();
         write_setting(ADDR_LED_SRC, 32'(random_bits(8)));
         drive_status();
         repeat (2) @(negedge dsp_clk);
      end
      finish_test("led_mux");

      for (int i = 0; i < N_TIME; i++) begin
         t = random_bits(64);
         k = 1 + int'(random_bits(3));
         // First load carries into the high word before the reads
         if (i == 0) begin
            t[31:0] = 32'hffff_fffa;
            k       = 8;
         end
         load_time(t);
         repeat (k) @(negedge dsp_clk);
         t = time_base + 64'(cycle - load_edge);
         read_expect(RB_TIME_LO, t[31:0]);
         t = time_base + 64'(cycle - load_edge);
         read_expect(RB_TIME_HI, t[63:32]);
      end
      finish_test("time_load_count");

      for (int i = 0; i < N_PPS; i++) begin
         repeat (2 + int'(random_bits(3))) @(negedge dsp_clk);
         pps = 1'b1;
         // Count present at the first high sample plus two
         t = time_base + 64'(cycle - load_edge) + 64'd2;
         repeat (3) @(negedge dsp_clk);
         read_expect(RB_PPS_HI, t[63:32]);
         read_expect(RB_PPS_LO, t[31:0]);
         pps = 1'b0;
         repeat (4) @(negedge dsp_clk);
      end
      finish_test("pps_capture");

      read_expect(RB_COMPAT, COMPAT_DEFAULT);
      for (int i = 0; i < 4; i++) begin
         drive_status();
         read_expect(RB_STATUS,
                     (set_data_t'(clk_status) << 11) | (set_data_t'(link_up) << 10));
      end
      write_setting(ADDR_SERDES, 32'(random_bits(4)));
      write_setting(ADDR_ADC, 32'(random_bits(4)));
      write_setting(ADDR_LED_SRC, 32'(random_bits(8)));
      read_expect(RB_CTRL, {16'd0, model_led_src, model_serdes, model_adc});
      read_expect(4'd7, '0);
      for (int i = 0; i < 3; i++) begin
         read_expect({1'b1, 3'(random_bits(3))}, '0);
      end
      finish_test("readback_words");

      $display("tests run %0d, passed %0d, failed %0d, assertion failures %0d",
               tests_run, tests_run - tests_failed, tests_failed,
               i_u2_ctrl_core.i_props.fail_cnt);
      if (tests_failed == 0 && i_u2_ctrl_core.i_props.fail_cnt == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
logic/u2_types_pkg.sv
logic/u2_regmap_pkg.sv
logic/settings_in.sv
logic/misc_regs.sv
logic/vita_timer.sv
logic/readback_mux.sv
logic/u2_ctrl_core.sv
sim/u2_ctrl_core_properties.sv
sim/u2_ctrl_core_tb.sv
